/* source/n64_ppu_pkg.sv */
// N64 post-processing unit package
// common widths, config/state word types and sync constants for the
// input side of the pixel pipeline

`default_nettype none

package n64_ppu_pkg;

  // ============================================================
  // vector types
  // ============================================================

  typedef logic [6:0] vd_in_t;       // raw word on the N64 video bus
  typedef logic [6:0] color_in_t;    // color before gamma
  typedef logic [7:0] color_out_t;   // color after gamma
  typedef logic [3:0] gamma_t;       // gamma setting 0..8
  typedef logic [9:0] line_cnt_t;    // lines per field

  // config word
  //   [3:0] gamma setting
  //   [4]   16-bit color mode enable
  //   [7:5] unused
  typedef logic [7:0] cfg_word_t;

  // state word
  //   [0] data detected, [1] pal, [2] interlaced
  //   [3] 16-bit mode in effect, [7:4] gamma in effect
  typedef logic [7:0] ppu_state_t;

  // ============================================================
  // constants
  // ============================================================

  localparam gamma_t GAMMA_UNITY = 4'd5;  // straight line
  localparam gamma_t GAMMA_MAX   = 4'd8;  // highest legal setting

  localparam int CFG_N16BIT_BIT = 4;

  // positions inside the sync word, both active low
  localparam int VSYNC_BIT = 3;
  localparam int HSYNC_BIT = 1;

endpackage

`default_nettype wire

/* source/ppu_cfg_sync.sv */
// configuration sync
// brings the config word into the N64 clock domain through two register
// stages and decodes the gamma setting and the 16-bit color enable

`timescale 1ns/1ps
`default_nettype none

module ppu_cfg_sync
  import n64_ppu_pkg::*;
(
  input  wire       N64_CLK_i,
  input  wire       rst_n_i,
  input  cfg_word_t cfg_i,
  output gamma_t    gamma_sel_o,
  output logic      n16bit_en_o
);

  cfg_word_t cfg_meta;  // first stage, may go metastable
  cfg_word_t cfg_sync;  // second stage, safe to decode
  gamma_t    gamma_raw;

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_meta <= '0;
      cfg_sync <= '0;
    end else begin
      cfg_meta <= cfg_i;
      cfg_sync <= cfg_meta;
    end
  end

  // ============================================================
  // decode
  // ============================================================

  assign gamma_raw = cfg_sync[3:0];

  // out of range settings fall back to unity
  assign gamma_sel_o = (gamma_raw > GAMMA_MAX) ? GAMMA_UNITY : gamma_raw;

  assign n16bit_en_o = cfg_sync[CFG_N16BIT_BIT];

endmodule

`default_nettype wire

/* source/n64_vinfo.sv */
// N64 video info
// derives data detected, PAL and interlaced from the sync words and
// makes an active-low mode-change pulse when PAL or detected changes

`timescale 1ns/1ps
`default_nettype none

module n64_vinfo
  import n64_ppu_pkg::*;
#(
  parameter line_cnt_t pal_line_threshold = 10'd288
) (
  input  wire        N64_CLK_i,
  input  wire        rst_n_i,
  input  wire        sync_strobe_i,
  input  wire  [3:0] sync_i,
  output logic       detected_o,
  output logic       pal_o,
  output logic       interlaced_o,
  output logic       mode_change_n_o
);

  logic [3:0] sync_prev;   // last sync word seen
  logic       vs_fall;
  logic       hs_fall;
  line_cnt_t  line_cnt;
  logic       field_seen;  // first vsync fall passed
  logic       hs_at_vs;    // hsync level at the last vsync fall
  logic [1:0] pal_hist;
  logic [1:0] det_hist;

  // ============================================================
  // edge detection on the sync words
  // ============================================================

  assign vs_fall = sync_strobe_i & sync_prev[VSYNC_BIT] & ~sync_i[VSYNC_BIT];
  assign hs_fall = sync_strobe_i & sync_prev[HSYNC_BIT] & ~sync_i[HSYNC_BIT];

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_prev <= 4'hf;  // syncs idle high
    end else if (sync_strobe_i) begin
      sync_prev <= sync_i;
    end
  end

  // lines per field
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_cnt <= '0;
    end else if (vs_fall) begin
      // an hsync fall in the vsync word opens line one of the new field
      line_cnt <= hs_fall ? line_cnt_t'(1) : '0;
    end else if (hs_fall && (line_cnt != '1)) begin
      line_cnt <= line_cnt + 1'b1;  // saturates
    end
  end

  // ============================================================
  // flags, updated once per field
  // ============================================================

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      field_seen   <= 1'b0;
      hs_at_vs     <= 1'b0;
      detected_o   <= 1'b0;
      pal_o        <= 1'b0;
      interlaced_o <= 1'b0;
    end else if (vs_fall) begin
      field_seen <= 1'b1;
      hs_at_vs   <= sync_i[HSYNC_BIT];
      // a full field lies behind us only from the second fall on
      if (field_seen) begin
        detected_o   <= 1'b1;  // sticky until reset
        pal_o        <= (line_cnt > pal_line_threshold);
        interlaced_o <= (sync_i[HSYNC_BIT] != hs_at_vs);
      end
    end
  end

  // ============================================================
  // mode change pulse
  // ============================================================

  // comparing against the value two clocks back keeps the pulse low
  // for two cycles
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pal_hist        <= 2'b00;
      det_hist        <= 2'b00;
      mode_change_n_o <= 1'b1;
    end else begin
      pal_hist        <= {pal_hist[0], pal_o};
      det_hist        <= {det_hist[0], detected_o};
      mode_change_n_o <= ~((pal_hist[1] ^ pal_o) | (det_hist[1] ^ detected_o));
    end
  end

endmodule

`default_nettype wire

/* source/n64_vdemux.sv */
// N64 video demux
// splits each sync/R/G/B word group into one pixel, applies the optional
// 16-bit color reduction and hands every sync word on to the video info

`timescale 1ns/1ps
`default_nettype none

module n64_vdemux
  import n64_ppu_pkg::*;
(
  input  wire        N64_CLK_i,
  input  wire        rst_n_i,
  input  wire        nvdsync_i,
  input  vd_in_t     vd_i,
  input  wire        n16bit_en_i,
  output logic       sync_strobe_o,
  output logic [3:0] sync_o,
  output logic       demux_valid_o,
  output logic       vsync_o,
  output logic       hsync_o,
  output color_in_t  red_o,
  output color_in_t  green_o,
  output color_in_t  blue_o
);

  // which word of the group is expected next
  typedef enum logic [1:0] {PH_IDLE, PH_RED, PH_GREEN, PH_BLUE} phase_t;

  localparam color_in_t MASK_16BIT = 7'b1111100;  // 5 bits per color left

  phase_t     phase;
  logic       pix_rdy;  // blue word just captured
  logic [3:0] sync_q;
  color_in_t  red_q;
  color_in_t  green_q;
  color_in_t  blue_q;

  function automatic color_in_t reduce(input color_in_t c, input logic en);
    return en ? (c & MASK_16BIT) : c;
  endfunction

  // ============================================================
  // phase FSM
  // ============================================================

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase         <= PH_IDLE;
      pix_rdy       <= 1'b0;
      sync_strobe_o <= 1'b0;
      demux_valid_o <= 1'b0;
    end else begin
      sync_strobe_o <= ~nvdsync_i;
      demux_valid_o <= pix_rdy;
      pix_rdy       <= nvdsync_i && (phase == PH_BLUE);
      if (!nvdsync_i) begin
        phase <= PH_RED;  // every sync word restarts the group
      end else begin
        case (phase)
          PH_RED:   phase <= PH_GREEN;
          PH_GREEN: phase <= PH_BLUE;
          PH_BLUE:  phase <= PH_IDLE;
          default:  phase <= PH_IDLE;
        endcase
      end
    end
  end

  // ============================================================
  // capture and output
  // ============================================================

  always_ff @(posedge N64_CLK_i) begin
    if (!nvdsync_i) begin
      sync_q <= vd_i[3:0];
    end else begin
      case (phase)
        PH_RED:   red_q   <= vd_i;
        PH_GREEN: green_q <= vd_i;
        PH_BLUE:  blue_q  <= vd_i;
        default:  ;
      endcase
    end

    if (pix_rdy) begin
      vsync_o <= ~sync_q[VSYNC_BIT];  // active high from here on
      hsync_o <= ~sync_q[HSYNC_BIT];
      red_o   <= reduce(red_q, n16bit_en_i);
      green_o <= reduce(green_q, n16bit_en_i);
      blue_o  <= reduce(blue_q, n16bit_en_i);
    end
  end

  assign sync_o = sync_q;  // raw word, qualified by sync_strobe_o

endmodule

`default_nettype wire

/* source/gamma_corr.sv */
// gamma correction
// two-stage pipeline, expands 7-bit colors to 8 bits and bends them
// along x + k/8 * x*(255-x)/256 with k = 5 - gamma

`timescale 1ns/1ps
`default_nettype none

module gamma_corr
  import n64_ppu_pkg::*;
(
  input  wire        N64_CLK_i,
  input  wire        rst_n_i,
  input  gamma_t     gamma_sel_i,
  input  wire        valid_i,
  input  wire        vsync_i,
  input  wire        hsync_i,
  input  color_in_t  red_i,
  input  color_in_t  green_i,
  input  color_in_t  blue_i,
  output logic       valid_o,
  output logic       vsync_o,
  output logic       hsync_o,
  output color_out_t red_o,
  output color_out_t green_o,
  output color_out_t blue_o
);

  gamma_t     gamma_eff;
  logic       k_neg;
  gamma_t     k_mag;
  logic       valid_s1, vsync_s1, hsync_s1;
  logic       k_neg_s1;
  gamma_t     k_mag_s1;
  color_out_t x_r_s1, x_g_s1, x_b_s1;
  color_out_t m_r_s1, m_g_s1, m_b_s1;

  // top bit repeated into the new lsb
  function automatic color_out_t expand(input color_in_t c);
    return {c, c[6]};
  endfunction

  function automatic color_out_t curve(input color_out_t x);
    logic [15:0] prod;
    prod = x * (8'd255 - x);
    return prod[15:8];
  endfunction

  function automatic color_out_t apply_k(input color_out_t x, input color_out_t m,
                                         input logic neg, input gamma_t mag);
    logic [11:0] step;
    step = (m * mag) >> 3;
    return neg ? (x - step[7:0]) : (x + step[7:0]);  // stays in 0..255
  endfunction

  // signed step as sign and magnitude
  assign gamma_eff = (gamma_sel_i > GAMMA_MAX) ? GAMMA_UNITY : gamma_sel_i;
  assign k_neg     = (gamma_eff > GAMMA_UNITY);
  assign k_mag     = k_neg ? (gamma_eff - GAMMA_UNITY) : (GAMMA_UNITY - gamma_eff);

  // ============================================================
  // stage 1, expand and curve
  // ============================================================

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) valid_s1 <= 1'b0;
    else          valid_s1 <= valid_i;
  end

  always_ff @(posedge N64_CLK_i) begin
    if (valid_i) begin
      vsync_s1 <= vsync_i;
      hsync_s1 <= hsync_i;
      k_neg_s1 <= k_neg;
      k_mag_s1 <= k_mag;
      x_r_s1   <= expand(red_i);
      x_g_s1   <= expand(green_i);
      x_b_s1   <= expand(blue_i);
      m_r_s1   <= curve(expand(red_i));
      m_g_s1   <= curve(expand(green_i));
      m_b_s1   <= curve(expand(blue_i));
    end
  end

  // ============================================================
  // stage 2, apply k
  // ============================================================

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      vsync_o <= 1'b0;
      hsync_o <= 1'b0;
      red_o   <= '0;
      green_o <= '0;
      blue_o  <= '0;
    end else begin
      valid_o <= valid_s1;
      if (valid_s1) begin
        vsync_o <= vsync_s1;
        hsync_o <= hsync_s1;
        red_o   <= apply_k(x_r_s1, m_r_s1, k_neg_s1, k_mag_s1);
        green_o <= apply_k(x_g_s1, m_g_s1, k_neg_s1, k_mag_s1);
        blue_o  <= apply_k(x_b_s1, m_b_s1, k_neg_s1, k_mag_s1);
      end
    end
  end

endmodule

`default_nettype wire

/* source/n64_ppu_top.sv */
// N64 post-processing unit, input side
// config sync, video info, demux and gamma correction in the N64 clock
// domain, plus the state word for the controller

`timescale 1ns/1ps
`default_nettype none

module n64_ppu_top
  import n64_ppu_pkg::*;
#(
  parameter line_cnt_t pal_line_threshold = 10'd288
) (
  input  wire        N64_CLK_i,
  input  wire        rst_n_i,
  input  wire        nvdsync_i,
  input  vd_in_t     vd_i,
  input  cfg_word_t  cfg_i,
  output ppu_state_t ppu_state_o,
  output logic       mode_change_n_o,
  output logic       pix_valid_o,
  output logic       vsync_o,
  output logic       hsync_o,
  output color_out_t red_o,
  output color_out_t green_o,
  output color_out_t blue_o
);

  gamma_t     gamma_sel;
  logic       n16bit_en;
  logic       sync_strobe;
  logic [3:0] sync_nib;
  logic       demux_valid;
  logic       dmx_vsync, dmx_hsync;
  color_in_t  dmx_red, dmx_green, dmx_blue;
  logic       detected, pal, interlaced;

  // ============================================================
  // configuration
  // ============================================================

  ppu_cfg_sync cfg_sync_u (
    .N64_CLK_i   (N64_CLK_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg_i),
    .gamma_sel_o (gamma_sel),
    .n16bit_en_o (n16bit_en)
  );

  // ============================================================
  // video info and demux
  // ============================================================

  n64_vdemux vdemux_u (
    .N64_CLK_i     (N64_CLK_i),
    .rst_n_i       (rst_n_i),
    .nvdsync_i     (nvdsync_i),
    .vd_i          (vd_i),
    .n16bit_en_i   (n16bit_en),
    .sync_strobe_o (sync_strobe),
    .sync_o        (sync_nib),
    .demux_valid_o (demux_valid),
    .vsync_o       (dmx_vsync),
    .hsync_o       (dmx_hsync),
    .red_o         (dmx_red),
    .green_o       (dmx_green),
    .blue_o        (dmx_blue)
  );

  n64_vinfo #(
    .pal_line_threshold (pal_line_threshold)
  ) vinfo_u (
    .N64_CLK_i       (N64_CLK_i),
    .rst_n_i         (rst_n_i),
    .sync_strobe_i   (sync_strobe),
    .sync_i          (sync_nib),
    .detected_o      (detected),
    .pal_o           (pal),
    .interlaced_o    (interlaced),
    .mode_change_n_o (mode_change_n_o)
  );

  // ============================================================
  // gamma, drives the pixel outputs
  // ============================================================

  gamma_corr gamma_u (
    .N64_CLK_i   (N64_CLK_i),
    .rst_n_i     (rst_n_i),
    .gamma_sel_i (gamma_sel),
    .valid_i     (demux_valid),
    .vsync_i     (dmx_vsync),
    .hsync_i     (dmx_hsync),
    .red_i       (dmx_red),
    .green_i     (dmx_green),
    .blue_i      (dmx_blue),
    .valid_o     (pix_valid_o),
    .vsync_o     (vsync_o),
    .hsync_o     (hsync_o),
    .red_o       (red_o),
    .green_o     (green_o),
    .blue_o      (blue_o)
  );

  // gamma in [7:4], then 16-bit mode and the three flags
  assign ppu_state_o = {gamma_sel, n16bit_en, interlaced, pal, detected};

endmodule

`default_nettype wire

/* verif/n64_ppu_checker.sv */
// N64 PPU protocol checker
// concurrent assertions on the top-level outputs, bound into the DUT

`timescale 1ns/1ps
`default_nettype none

module n64_ppu_checker (
  input wire       N64_CLK_i,
  input wire       rst_n_i,
  input wire       pix_valid_i,
  input wire       mode_change_n_i,
  input wire       vsync_i,
  input wire       hsync_i,
  input wire [7:0] red_i,
  input wire [7:0] green_i,
  input wire [7:0] blue_i
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  // one pixel per four bus words
  a_valid_single: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    pix_valid_i |=> !pix_valid_i)
    else begin
      fail_cnt++;
      $error("pix_valid_o was high on two consecutive cycles");
    end

  a_mode_pulse: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    (!mode_change_n_i && !$past(mode_change_n_i)) |=> mode_change_n_i)
    else begin
      fail_cnt++;
      $error("mode_change_n_o stayed low for more than 2 cycles");
    end

  a_reset_quiet: assert property (@(posedge N64_CLK_i)
    !rst_n_i |-> (!pix_valid_i && !vsync_i && !hsync_i && mode_change_n_i &&
                  red_i == 8'd0 && green_i == 8'd0 && blue_i == 8'd0))
    else begin
      fail_cnt++;
      $error("outputs were not idle during reset");
    end

endmodule

bind n64_ppu_top n64_ppu_checker ppu_checker_u (
  .N64_CLK_i       (N64_CLK_i),
  .rst_n_i         (rst_n_i),
  .pix_valid_i     (pix_valid_o),
  .mode_change_n_i (mode_change_n_o),
  .vsync_i         (vsync_o),
  .hsync_i         (hsync_o),
  .red_i           (red_o),
  .green_i         (green_o),
  .blue_i          (blue_o)
);

`default_nettype wire

/* verif/n64_ppu_tb.sv */
// N64 PPU testbench
// drives NTSC and PAL fields with random colors into the input side and
// compares each pixel and the state word with a reference model

`timescale 1ns/1ps
`default_nettype none

module n64_ppu_tb;

  localparam int PIX_PER_LINE = 4;
  localparam int NTSC_LINES   = 263;
  localparam int PAL_LINES    = 313;
  localparam int NTSC_FIELDS  = 8;
  localparam int PAL_FIELDS   = 5;
  // four bus words per pixel, plus some slack for reset and drain
  localparam int TOTAL_CYCLES = (NTSC_FIELDS * NTSC_LINES + PAL_FIELDS * PAL_LINES)
                                * PIX_PER_LINE * 4 + 64;

  logic        n64_clk;
  logic        rst_n;
  logic        nvdsync;
  logic [6:0]  vd;
  logic [7:0]  cfg;
  logic [7:0]  ppu_state;
  logic        mode_change_n;
  logic        pix_valid;
  logic        vsync;
  logic        hsync;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;

  int          seed;
  int          rnd;
  string       test_name;
  logic [7:0]  cfg_cur;     // config the reference works with
  logic [7:0]  next_cfg;
  bit          cfg_change;  // apply next_cfg in the coming first line
  logic [26:0] exp_q[$];    // {check colors, vsync, hsync, r, g, b}
  string       name_q[$];
  logic [26:0] cmp_exp;
  string       cmp_name;
  int          mc_falls = 0;
  logic        mc_prev = 1'b1;

  n64_ppu_top #(
    .pal_line_threshold (10'd288)
  ) n64_ppu_top_inst (
    .N64_CLK_i       (n64_clk),
    .rst_n_i         (rst_n),
    .nvdsync_i       (nvdsync),
    .vd_i            (vd),
    .cfg_i           (cfg),
    .ppu_state_o     (ppu_state),
    .mode_change_n_o (mode_change_n),
    .pix_valid_o     (pix_valid),
    .vsync_o         (vsync),
    .hsync_o         (hsync),
    .red_o           (red),
    .green_o         (green),
    .blue_o          (blue)
  );

  initial begin
    n64_clk = 1'b0;
    forever #5 n64_clk = ~n64_clk;
  end

  // ============================================================
  // reference model
  // ============================================================

  function automatic logic [3:0] eff_gamma(input logic [3:0] g);
    return (g > 4'd8) ? 4'd5 : g;  // out of range acts as unity
  endfunction

  function automatic logic [7:0] gamma_ref(input logic [6:0] c, input logic [7:0] cfg_w);
    logic [6:0] cr;
    int         x;
    int         m;
    int         k;
    int         step;
    cr   = cfg_w[4] ? {c[6:2], 2'b00} : c;
    x    = int'({cr, cr[6]});
    m    = (x * (255 - x)) / 256;
    k    = 5 - int'(eff_gamma(cfg_w[3:0]));
    step = (m * ((k < 0) ? -k : k)) / 8;
    return (k < 0) ? 8'(x - step) : 8'(x + step);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  // ============================================================
  // stimulus
  // ============================================================

  // one sync/R/G/B group, expected pixel queued with it
  task automatic emit_group(input logic vs_lvl, input logic hs_lvl, input bit may_change);
    logic [31:0] rw;
    logic [6:0]  sync_w;
    bit          chk;
    chk       = 1'b1;
    rw        = $random(seed);
    sync_w    = rw[30:24];
    sync_w[3] = vs_lvl;
    sync_w[1] = hs_lvl;
    @(negedge n64_clk);
    if (may_change && cfg_change) begin
      cfg        = next_cfg;
      cfg_cur    = next_cfg;
      cfg_change = 1'b0;
      chk        = 1'b0;  // config still on its way through the sync
    end
    exp_q.push_back({chk, ~vs_lvl, ~hs_lvl, gamma_ref(rw[6:0], cfg_cur),
                     gamma_ref(rw[14:8], cfg_cur), gamma_ref(rw[22:16], cfg_cur)});
    name_q.push_back(test_name);
    nvdsync = 1'b0;
    vd      = sync_w;
    @(negedge n64_clk);
    nvdsync = 1'b1;
    vd      = rw[6:0];
    @(negedge n64_clk);
    vd = rw[14:8];
    @(negedge n64_clk);
    vd = rw[22:16];
  endtask

  task automatic emit_field(input int lines, input int ppl, input logic hs_at_vs);
    logic vs_lvl;
    logic hs_lvl;
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < ppl; p++) begin
        vs_lvl = !(l == 0 && p == 0);
        hs_lvl = (p != 0) ? 1'b1 : ((l == 0) ? hs_at_vs : 1'b0);
        emit_group(vs_lvl, hs_lvl, (l == 0 && p == 1));
      end
    end
  endtask

  task automatic check_state(input logic det, input logic pal, input logic il);
    logic [7:0] exp_state;
    exp_state = {eff_gamma(cfg_cur[3:0]), cfg_cur[4], il, pal, det};
    assert (ppu_state == exp_state) else
      abort_run($sformatf("mismatch %s: state expected %h actual %h",
                          test_name, exp_state, ppu_state));
  endtask

  task automatic check_mode_changes(input int exp_falls);
    assert (mc_falls == exp_falls) else
      abort_run($sformatf("mismatch %s: mode change pulses expected %0d actual %0d",
                          test_name, exp_falls, mc_falls));
  endtask

  // ============================================================
  // compare and monitors
  // ============================================================

  always @(negedge n64_clk) begin
    if (rst_n && pix_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("the DUT put out a pixel that was never sent");
      end else begin
        cmp_exp  = exp_q.pop_front();
        cmp_name = name_q.pop_front();
        assert ({vsync, hsync} == cmp_exp[25:24]) else
          abort_run($sformatf("mismatch %s: sync expected %b actual %b",
                              cmp_name, cmp_exp[25:24], {vsync, hsync}));
        if (cmp_exp[26]) begin
          assert ({red, green, blue} == cmp_exp[23:0]) else
            abort_run($sformatf("mismatch %s: rgb expected %h actual %h",
                                cmp_name, cmp_exp[23:0], {red, green, blue}));
        end
      end
    end
  end

  // counts falling edges of the mode-change pulse
  always @(negedge n64_clk) begin
    if (mc_prev && !mode_change_n) mc_falls = mc_falls + 1;
    mc_prev = mode_change_n;
  end

  // protocol checker bound into the DUT
  always @(negedge n64_clk) begin
    if (n64_ppu_top_inst.ppu_checker_u.fail_cnt != 0) begin
      abort_run("the bound protocol checker flagged an assertion");
    end
  end

  initial begin
    repeat (2 * TOTAL_CYCLES) @(posedge n64_clk);
    abort_run("timeout, the pixel stream did not finish in time");
  end

  // ============================================================
  // test sequence
  // ============================================================

  initial begin
    seed       = 8;
    nvdsync    = 1'b1;
    vd         = '0;
    cfg        = 8'h05;  // unity gamma, 16-bit off
    cfg_cur    = 8'h05;
    next_cfg   = 8'h05;
    cfg_change = 1'b0;
    test_name  = "reset";
    rst_n      = 1'b1;
    #1 rst_n = 1'b0;
    repeat (2) @(posedge n64_clk);
    @(negedge n64_clk);
    rst_n = 1'b1;

    // NTSC progressive, pixel path at unity
    test_name = "ntsc_unity";
    emit_field(NTSC_LINES, PIX_PER_LINE, 1'b0);
    emit_field(NTSC_LINES, PIX_PER_LINE, 1'b0);
    check_state(1'b1, 1'b0, 1'b0);
    check_mode_changes(1);  // detected came up

    test_name = "gamma";
    for (int i = 0; i < 4; i++) begin
      rnd        = $random(seed);
      next_cfg   = {4'h0, (i == 0) ? 4'd12 : rnd[3:0]};  // first one out of range
      cfg_change = 1'b1;
      emit_field(NTSC_LINES, PIX_PER_LINE, 1'b0);
      check_state(1'b1, 1'b0, 1'b0);
    end

    test_name = "color16";
    for (int i = 0; i < 2; i++) begin
      rnd        = $random(seed);
      next_cfg   = {3'b000, 1'b1, rnd[3:0]};
      cfg_change = 1'b1;
      emit_field(NTSC_LINES, PIX_PER_LINE, 1'b0);
      check_state(1'b1, 1'b0, 1'b0);
    end

    // PAL flag follows one field behind the line count
    test_name  = "pal";
    next_cfg   = 8'h05;
    cfg_change = 1'b1;
    emit_field(PAL_LINES, PIX_PER_LINE, 1'b0);
    check_state(1'b1, 1'b0, 1'b0);
    emit_field(PAL_LINES, PIX_PER_LINE, 1'b0);
    check_state(1'b1, 1'b1, 1'b0);
    check_mode_changes(2);

    test_name = "interlace";
    emit_field(PAL_LINES, PIX_PER_LINE, 1'b1);
    check_state(1'b1, 1'b1, 1'b1);
    emit_field(PAL_LINES, PIX_PER_LINE, 1'b0);
    check_state(1'b1, 1'b1, 1'b1);
    emit_field(PAL_LINES, PIX_PER_LINE, 1'b0);
    check_state(1'b1, 1'b1, 1'b0);
    check_mode_changes(2);

    // let the last pixels drain
    @(negedge n64_clk);
    nvdsync = 1'b1;
    vd      = '0;
    while (exp_q.size() != 0) @(negedge n64_clk);
    repeat (8) @(negedge n64_clk);

    if (n64_ppu_top_inst.ppu_checker_u.fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run("the bound protocol checker flagged an assertion");
    end
  end

endmodule

`default_nettype wire

/* n64_ppu_top.f */
source/n64_ppu_pkg.sv
source/ppu_cfg_sync.sv
source/n64_vinfo.sv
source/n64_vdemux.sv
source/gamma_corr.sv
source/n64_ppu_top.sv
verif/n64_ppu_checker.sv
verif/n64_ppu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the N64 PPU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module n64_ppu_tb \
  -f n64_ppu_top.f \
  -o n64_ppu_sim

# the testbench exit status is not used, the printed result decides
sim_out=$(./obj_dir/n64_ppu_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
